// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_mem_test_engine
FILELIST   := mem_test_engine.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Exit status of the simulation is the pass or fail result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/mem_test_engine_assert.sv ====
// Watches the request port only; almost-full is taken as a level sampled on the rising edge
module mem_test_engine_assert
(
    input logic                  clk,
    input logic                  reset_n,
    input logic                  rd_almost_full,
    input mem_test_pkg::rd_req_t rd_req
);
    import mem_test_pkg::*;

    // ======================================================================
    // Request port rules
    // ======================================================================

    // No new request in the cycle after almost-full was seen
    no_req_after_full: assert property (@(posedge clk) disable iff (!reset_n)
        rd_almost_full |=> !rd_req.valid)
        else $error("read request issued the cycle after almost-full");

    // Burst code 3 never leaves the engine
    legal_burst: assert property (@(posedge clk) disable iff (!reset_n)
        rd_req.valid |-> (rd_req.burst != 2'd3))
        else $error("illegal burst code on a read request");

    // Strobe low once reset has been applied
    idle_after_reset: assert property (@(posedge clk) !reset_n |=> !rd_req.valid)
        else $error("read request valid high after reset");

endmodule

bind mem_test_engine mem_test_engine_assert req_checks (.clk, .reset_n, .rd_almost_full,
                                                        .rd_req);

// ==== dv/tb_mem_test_engine.sv ====
// Testbench acts as the memory and accepts every request; random stimulus from a fixed-seed LCG
module tb_mem_test_engine;
    import mem_test_pkg::*;

    logic        clk = 1'b0;
    logic        reset_n;
    csr_wr_t     csr_wr;
    stat_idx_e   stat_idx;
    logic [63:0] stat_data;
    logic        state_reset;
    logic        state_run;
    logic        rd_almost_full = 1'b0;
    rd_req_t     rd_req;
    rd_rsp_t     rd_rsp = '0;
    logic        active;

    // Model view of the configuration written by the stimulus
    string       test_name;
    addr_t       cfg_base;
    offset_t     cfg_mask;
    offset_t     cfg_start;
    burst_len_e  cfg_burst;
    logic        af_random;

    // Model state owned by the memory process
    logic [31:0] lcg_state = 32'h9284_a6b2;
    offset_t     exp_offset;
    tag_t        exp_tag;
    counter_t    req_count;
    counter_t    model_lines;
    logic [31:0] model_sum;
    logic [31:0] model_hash;
    logic        af_prev;
    line_t       line_q[$];
    tag_t        tag_q[$];

    mem_test_engine uut (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Lines per burst code
    function automatic int lines_of(burst_len_e b);
        return (b == burst_4) ? 4 : ((b == burst_2) ? 2 : 1);
    endfunction

    function automatic line_t make_line();
        line_t l;
        for (int w = 0; w < 16; w++)
            l[w*32 +: 32] = lcg_next();
        return l;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act)
            fail_run($sformatf("error %s: expected %0h, actual %0h", name, exp, act));
    endtask

    // ======================================================================
    // Memory responder and reference model
    // ======================================================================
    always @(posedge clk)
    begin
        logic [31:0] r;
        logic [31:0] word;
        line_t       line;
        int          n;
        r = lcg_next();
        rd_almost_full <= af_random && (r[1:0] == 2'd0);
        if (state_reset)
        begin
            // Follows the engine restart
            exp_offset = cfg_start;
            exp_tag = '0;
            req_count = '0;
            model_lines = '0;
            model_sum = '0;
            model_hash = '0;
        end
        if (reset_n && rd_req.valid)
        begin
            if (af_prev)
                fail_run("read request issued one cycle after almost-full was high");
            check_value({test_name, " addr"}, 64'(cfg_base + addr_t'(exp_offset)),
                        64'(rd_req.addr));
            check_value({test_name, " tag"}, 64'(exp_tag), 64'(rd_req.tag));
            check_value({test_name, " burst"}, 64'(cfg_burst), 64'(rd_req.burst));
            n = lines_of(cfg_burst);
            for (int i = 0; i < n; i++)
            begin
                line_q.push_back(make_line());
                tag_q.push_back(rd_req.tag);
            end
            // Offset advances by the burst and wraps at the mask
            exp_offset = (exp_offset + offset_t'(n)) & cfg_mask;
            exp_tag = exp_tag + tag_t'(1);
            req_count = req_count + counter_t'(1);
            model_lines = model_lines + counter_t'(n);
        end
        af_prev = rd_almost_full;
        // Lines return in order with random gaps
        r = lcg_next();
        if (line_q.size() != 0 && r[1:0] != 2'd0)
        begin
            line = line_q.pop_front();
            rd_rsp <= '{valid: 1'b1, tag: tag_q.pop_front(), data: line};
            word = {line[DATA_WIDTH-1 -: 16], line[15:0]};
            model_sum = model_sum + word;
            model_hash = {model_hash[30:0], model_hash[31]} ^ word;
        end
        else
            rd_rsp.valid <= 1'b0;
    end

    // ======================================================================
    // Stimulus tasks
    // ======================================================================
    task automatic write_csr(input logic [3:0] idx, input logic [63:0] data);
        @(posedge clk);
        csr_wr <= '{valid: 1'b1, idx: idx, data: data};
        @(posedge clk);
        csr_wr <= '0;
    endtask

    task automatic read_status(input stat_idx_e idx, output logic [63:0] value);
        @(posedge clk);
        stat_idx <= idx;
        @(negedge clk);
        value = stat_data;
    endtask

    // Pulse the engine reset level while the model clears alongside
    task automatic restart_engine();
        @(posedge clk);
        state_reset <= 1'b1;
        repeat (3) @(posedge clk);
        state_reset <= 1'b0;
        repeat (3) @(negedge clk);
    endtask

    task automatic start_test(input string name, input addr_t base, input logic [15:0] start,
                              input offset_t mask, input burst_len_e burst,
                              input logic [15:0] count, input logic random_af);
        test_name = name;
        cfg_base = base;
        cfg_mask = mask;
        cfg_start = offset_t'(start);
        cfg_burst = burst;
        write_csr(cfg_rd_base, 64'(base));
        write_csr(cfg_addr_mask, 64'(mask));
        // Count 47:32, start offset 31:16, burst code 1:0
        write_csr(cfg_rd_ctrl, {16'h0, count, start, 14'h0, burst});
        restart_engine();
        af_random = random_af;
        @(posedge clk);
        state_run <= 1'b1;
    endtask

    task automatic stop_run();
        @(posedge clk);
        state_run <= 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_requests(input int count);
        int cycles;
        cycles = 0;
        while (req_count < counter_t'(count) && cycles < 6000)
        begin
            @(negedge clk);
            cycles++;
        end
        if (req_count < counter_t'(count))
            fail_run($sformatf("timeout in %s waiting for read requests", test_name));
    endtask

    // Outstanding lines returned and active low
    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while ((line_q.size() != 0 || active) && cycles < 6000)
        begin
            @(negedge clk);
            cycles++;
        end
        if (line_q.size() != 0 || active)
            fail_run($sformatf("timeout in %s waiting for the engine to go idle", test_name));
    endtask

    task automatic check_status();
        logic [63:0] v;
        read_status(stat_rd_bursts, v);
        check_value({test_name, " status bursts"}, 64'(req_count), v);
        read_status(stat_rd_lines, v);
        check_value({test_name, " status lines"}, 64'(model_lines), v);
        read_status(stat_rd_check, v);
        check_value({test_name, " status sum and hash"}, {model_sum, model_hash}, v);
    endtask

    // Bounded run counts requests, drains, then compares status
    task automatic finish_test(input int count);
        wait_requests(count);
        wait_drain();
        af_random = 1'b0;
        repeat (8) @(negedge clk);
        check_value({test_name, " request count"}, 64'(count), 64'(req_count));
        check_value({test_name, " active after drain"}, 64'h0, 64'(active));
        check_status();
        stop_run();
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial
    begin
        logic [63:0] cfg_word;
        test_name = "reset";
        af_random = 1'b0;
        cfg_start = '0;
        reset_n <= 1'b0;
        csr_wr <= '0;
        stat_idx <= stat_config;
        state_reset <= 1'b0;
        state_run <= 1'b0;
        repeat (5) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_value("reset valid", 64'h0, 64'(rd_req.valid));
        check_value("reset active", 64'h0, 64'(active));
        check_value("reset config", 64'h0000_0000_0020_0004, stat_data);

        start_test("count_burst_2", 42'h100_0000, 16'h0010, '1, burst_2, 16'd10, 1'b0);
        finish_test(10);
        start_test("almost_full", 42'h2_0000_0000, 16'h0100, '1, burst_1, 16'd40, 1'b1);
        finish_test(40);
        // Small mask wraps the offset with each burst code
        start_test("wrap_burst_1", 42'h300, 16'h0003, 32'hf, burst_1, 16'd20, 1'b1);
        finish_test(20);
        start_test("wrap_burst_2", 42'h300, 16'h0005, 32'hf, burst_2, 16'd20, 1'b1);
        finish_test(20);
        start_test("wrap_burst_4", 42'h300, 16'h0003, 32'hf, burst_4, 16'd20, 1'b1);
        finish_test(20);

        start_test("zero_base", 42'h0, 16'h0000, '1, burst_1, 16'd5, 1'b0);
        repeat (30) @(negedge clk);
        check_value("zero_base requests", 64'h0, 64'(req_count));
        check_value("zero_base active", 64'h0, 64'(active));
        stop_run();

        // Runs past the tag wrap and stays active while running
        start_test("unlimited", 42'h4_0000, 16'h0008, 32'h3f, burst_2, 16'd0, 1'b1);
        wait_requests(280);
        check_value("unlimited active", 64'h1, 64'(active));
        // Active and run bits set with the reset level clear
        read_status(stat_config, cfg_word);
        check_value("unlimited config", 64'h0000_0006_0020_0004, cfg_word);
        stop_run();
        repeat (4) @(negedge clk);
        wait_drain();
        af_random = 1'b0;
        repeat (8) @(negedge clk);
        check_status();

        test_name = "clear";
        restart_engine();
        check_status();

        $display("No errors");
        $finish;
    end

endmodule

// ==== hdl/engine_csr.sv ====
// Writes to unlisted indices are dropped and unlisted status indices read zero
module engine_csr
(
    input  logic                     clk,
    input  logic                     reset_n,
    input  mem_test_pkg::csr_wr_t    csr_wr,
    input  mem_test_pkg::stat_idx_e  stat_idx,
    input  mem_test_pkg::rd_status_t status,
    input  logic                     run,
    input  logic                     in_reset,
    input  logic                     active,
    output mem_test_pkg::rd_cfg_t    rd_cfg,
    output logic [63:0]              stat_data
);
    import mem_test_pkg::*;

    // ======================================================================
    // Configuration writes
    // ======================================================================

    // Register 0 is the base, 2 the control word, 4 the offset mask
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_cfg.base <= '0;
            rd_cfg.start_offset <= '0;
            // Full mask so offsets never wrap until software narrows it
            rd_cfg.mask <= '1;
            rd_cfg.burst <= burst_1;
            rd_cfg.num_bursts <= '0;
        end
        else if (csr_wr.valid)
        begin
            case (csr_wr.idx)
                cfg_rd_base:
                begin
                    rd_cfg.base <= addr_t'(csr_wr.data);
                end
                cfg_rd_ctrl:
                begin
                    // Count in 47:32, offset in 31:16, burst code in 1:0
                    rd_cfg.num_bursts <= csr_wr.data[47:32];
                    rd_cfg.start_offset <= offset_t'(csr_wr.data[31:16]);
                    rd_cfg.burst <= burst_len_e'(csr_wr.data[1:0]);
                end
                cfg_addr_mask:
                begin
                    rd_cfg.mask <= offset_t'(csr_wr.data);
                end
                default:
                begin
                    // Nothing else is writable
                end
            endcase
        end
    end

    // ======================================================================
    // Status read mux, same-cycle
    // ======================================================================
    always_comb
    begin
        case (stat_idx)
            // Engine state bits, mask width and largest burst
            stat_config: stat_data = {29'h0, active, run, in_reset, 16'(OFFSET_WIDTH),
                                      1'b0, 15'(MAX_BURST_LINES)};
            stat_rd_bursts: stat_data = 64'(status.bursts_req);
            stat_rd_lines: stat_data = 64'(status.lines_resp);
            // Sum high, hash low
            stat_rd_check: stat_data = {status.sum, status.hash};
            default: stat_data = 64'h0;
        endcase
    end

endmodule

// ==== hdl/mem_test_engine.sv ====
// Read-only test engine; no write path, and the memory may not stall an issued request
module mem_test_engine
(
    input  logic                    clk,
    input  logic                    reset_n,
    input  mem_test_pkg::csr_wr_t   csr_wr,
    input  mem_test_pkg::stat_idx_e stat_idx,
    output logic [63:0]             stat_data,
    input  logic                    state_reset,
    input  logic                    state_run,
    input  logic                    rd_almost_full,
    output mem_test_pkg::rd_req_t   rd_req,
    input  mem_test_pkg::rd_rsp_t   rd_rsp,
    output logic                    active
);
    import mem_test_pkg::*;

    rd_cfg_t    rd_cfg;
    rd_status_t status;
    logic       run;
    logic       in_reset;
    logic       done;
    counter_t   bursts_req;
    counter_t   lines_req;
    counter_t   lines_resp;
    logic [31:0] sum;
    logic [31:0] hash;

    // Configuration and status port
    engine_csr csr (.clk, .reset_n, .csr_wr, .stat_idx, .status, .run, .in_reset,
                    .active, .rd_cfg, .stat_data);

    // Request producer
    rd_req_gen req_gen (.clk, .reset_n, .rd_cfg, .state_reset, .state_run, .rd_almost_full,
                        .rd_req, .run, .in_reset, .done, .bursts_req, .lines_req);

    // Response consumer, cleared by the registered reset level
    rd_rsp_check rsp_check (.clk, .reset_n, .clear(in_reset), .rd_rsp, .sum, .hash,
                            .lines_resp);

    assign status = '{bursts_req: bursts_req, lines_resp: lines_resp, sum: sum, hash: hash};

    // ======================================================================
    // Engine state
    // ======================================================================

    // Busy while issuing or while lines are still outstanding
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            active <= 1'b0;
        else
            active <= (run && !done) || (lines_req != lines_resp);
    end

endmodule

// ==== hdl/mem_test_pkg.sv ====
// Shared types for the read test engine; burst code 3 is illegal, offsets are 32-bit line units
package mem_test_pkg;

    // ======================================================================
    // Widths
    // ======================================================================
    localparam int ADDR_WIDTH      = 42;
    localparam int DATA_WIDTH      = 512;
    localparam int OFFSET_WIDTH    = 32;
    localparam int COUNTER_WIDTH   = 48;
    localparam int TAG_WIDTH       = 8;
    localparam int CSR_IDX_WIDTH   = 4;
    localparam int MAX_BURST_LINES = 4;

    typedef logic [ADDR_WIDTH-1:0]    addr_t;
    typedef logic [OFFSET_WIDTH-1:0]  offset_t;
    typedef logic [COUNTER_WIDTH-1:0] counter_t;
    typedef logic [TAG_WIDTH-1:0]     tag_t;
    typedef logic [DATA_WIDTH-1:0]    line_t;
    typedef logic [15:0]              num_bursts_t;

    // Burst encoding, code 3 never issued
    typedef enum logic [1:0] {burst_1 = 2'd0, burst_2 = 2'd1, burst_4 = 2'd2} burst_len_e;

    // Writable configuration registers
    typedef enum logic [CSR_IDX_WIDTH-1:0] {
        cfg_rd_base = 4'd0, cfg_rd_ctrl = 4'd2, cfg_addr_mask = 4'd4
    } cfg_idx_e;

    // Readable status words
    typedef enum logic [CSR_IDX_WIDTH-1:0] {
        stat_config = 4'd0, stat_rd_bursts = 4'd1, stat_rd_lines = 4'd2, stat_rd_check = 4'd5
    } stat_idx_e;

    // ======================================================================
    // Bundles
    // ======================================================================
    typedef struct packed {logic valid; logic [CSR_IDX_WIDTH-1:0] idx; logic [63:0] data;} csr_wr_t;

    typedef struct packed {
        addr_t base; offset_t start_offset; offset_t mask; burst_len_e burst;
        num_bursts_t num_bursts;
    } rd_cfg_t;

    typedef struct packed {logic valid; addr_t addr; burst_len_e burst; tag_t tag;} rd_req_t;
    typedef struct packed {logic valid; tag_t tag; line_t data;} rd_rsp_t;

    typedef struct packed {
        counter_t bursts_req; counter_t lines_resp; logic [31:0] sum; logic [31:0] hash;
    } rd_status_t;

endpackage

// ==== hdl/rd_req_gen.sv ====
// Memory must accept every valid request; base plus offset is a plain add, no alignment check
module rd_req_gen
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  mem_test_pkg::rd_cfg_t  rd_cfg,
    input  logic                   state_reset,
    input  logic                   state_run,
    input  logic                   rd_almost_full,
    output mem_test_pkg::rd_req_t  rd_req,
    output logic                   run,
    output logic                   in_reset,
    output logic                   done,
    output mem_test_pkg::counter_t bursts_req,
    output mem_test_pkg::counter_t lines_req
);
    import mem_test_pkg::*;

    offset_t     offset;
    num_bursts_t bursts_left;
    logic        unlimited;
    tag_t        tag;
    logic        issue;

    // Lines covered by one burst code; the illegal code counts as one
    function automatic offset_t burst_lines(burst_len_e b);
        case (b)
            burst_2: return offset_t'(2);
            burst_4: return offset_t'(4);
            default: return offset_t'(1);
        endcase
    endfunction

    // Control levels sampled once before use
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            run <= 1'b0;
            in_reset <= 1'b0;
        end
        else
        begin
            run <= state_run;
            in_reset <= state_reset;
        end
    end

    // Request decision, almost-full taken straight from the memory
    assign issue = run && !done && !rd_almost_full;

    // ======================================================================
    // Request register
    // ======================================================================
    always_ff @(posedge clk)
    begin
        rd_req.addr <= rd_cfg.base + addr_t'(offset);
        rd_req.burst <= rd_cfg.burst;
        rd_req.tag <= tag;
        if (!reset_n)
            rd_req.valid <= 1'b0;
        else
            rd_req.valid <= issue;
    end

    // Offset, countdown and tag move on the same edge that sets valid
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            done <= 1'b1;
            offset <= '0;
            bursts_left <= '0;
            unlimited <= 1'b0;
            tag <= '0;
        end
        else if (in_reset)
        begin
            // Zero base keeps the engine idle
            done <= (rd_cfg.base == addr_t'(0));
            offset <= rd_cfg.start_offset;
            bursts_left <= rd_cfg.num_bursts;
            unlimited <= (rd_cfg.num_bursts == num_bursts_t'(0));
            tag <= '0;
        end
        else if (issue)
        begin
            done <= !unlimited && (bursts_left == num_bursts_t'(1));
            offset <= (offset + burst_lines(rd_cfg.burst)) & rd_cfg.mask;
            bursts_left <= bursts_left - num_bursts_t'(1);
            tag <= tag + tag_t'(1);
        end
    end

    // Issued bursts and lines, counted off the registered request
    always_ff @(posedge clk)
    begin
        if (!reset_n || in_reset)
        begin
            bursts_req <= '0;
            lines_req <= '0;
        end
        else if (rd_req.valid)
        begin
            bursts_req <= bursts_req + counter_t'(1);
            lines_req <= lines_req + counter_t'(burst_lines(rd_req.burst));
        end
    end

endmodule

// ==== hdl/rd_rsp_check.sv ====
// Only the top and bottom 16 data bits of each line are checked; response tags are not
module rd_rsp_check
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   clear,
    input  mem_test_pkg::rd_rsp_t  rd_rsp,
    output logic [31:0]            sum,
    output logic [31:0]            hash,
    output mem_test_pkg::counter_t lines_resp
);
    import mem_test_pkg::*;

    // Registered response stage
    logic        rsp_en;
    logic [31:0] rsp_word;

    // ======================================================================
    // Input stage
    // ======================================================================

    // Strobe is control, cleared at reset
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            rsp_en <= 1'b0;
        else
            rsp_en <= rd_rsp.valid;
    end

    // High 16 bits of the line in the upper half, low 16 in the lower half
    always_ff @(posedge clk)
    begin
        rsp_word <= {rd_rsp.data[DATA_WIDTH-1 -: 16], rd_rsp.data[15:0]};
    end

    // ======================================================================
    // Fold and count
    // ======================================================================

    // Sum is order-free, hash catches reordering
    always_ff @(posedge clk)
    begin
        if (!reset_n || clear)
        begin
            sum <= 32'h0;
            hash <= 32'h0;
        end
        else if (rsp_en)
        begin
            sum <= sum + rsp_word;
            // Rotate left one, then XOR in the new word
            hash <= {hash[30:0], hash[31]} ^ rsp_word;
        end
    end

    // Line count tracks the fold so it agrees with the check word
    always_ff @(posedge clk)
    begin
        if (!reset_n || clear)
            lines_resp <= '0;
        else if (rsp_en)
            lines_resp <= lines_resp + counter_t'(1);
    end

endmodule

// ==== mem_test_engine.f ====
hdl/mem_test_pkg.sv
hdl/engine_csr.sv
hdl/rd_req_gen.sv
hdl/rd_rsp_check.sv
hdl/mem_test_engine.sv
dv/mem_test_engine_assert.sv
dv/tb_mem_test_engine.sv
